// ==== mmc3_pkg.sv ====
`default_nettype none

package mmc3_pkg;

	// ****************************************
	// constants

	localparam logic [7:0] MAP_IDX = 8'd74;            // mapper number for save-state readback
	localparam int A12_QUIET_LEN = 4;                  // low samples before an a12 rise counts
	localparam logic [7:0] SS_IRQ_CTR_ADR = 8'd16;
	localparam logic [7:0] SS_IRQ_FLAGS_ADR = 8'd17;
	localparam logic [7:0] SS_MAP_IDX_ADR = 8'd127;
	localparam logic [5:0] PRG_FIXED_LAST = 6'b111111;   // e000-ffff window
	localparam logic [5:0] PRG_FIXED_SECOND = 6'b111110; // 8000 or c000 window

	// ****************************************
	// cpu register select, indexed by {a14, a13, a0}

	typedef enum logic [2:0] {
		bank_select = 3'd0, // 8000
		bank_data   = 3'd1, // 8001
		mirror      = 3'd2, // a000
		ram_cfg     = 3'd3, // a001
		irq_latch   = 3'd4, // c000
		irq_reload  = 3'd5, // c001
		irq_disable = 3'd6, // e000
		irq_enable  = 3'd7  // e001
	} reg_sel_e;

	// ****************************************
	// bus and block interfaces

	typedef struct packed {
		logic ce_n;        // low for 8000-ffff
		logic rw;          // high for read
		logic [14:0] addr;
		logic [7:0] dat;
	} cpu_bus_t;

	typedef struct packed {
		logic [13:0] addr;
		logic oe_n;
		logic we_n;
	} ppu_bus_t;

	typedef struct packed {
		logic [5:0][7:0] chr_bank; // 2k, 2k, 1k, 1k, 1k, 1k
		logic [1:0][5:0] prg_bank;
		logic swap_control;
		logic chr_invert;
		logic mirror_mode;         // 0 vertical, 1 horizontal
		logic ram_on;
	} bank_cfg_t;

	// restore loads the counter from restore_ctr, restore_on loads the
	// flags from the same byte in the save-state flag layout
	typedef struct packed {
		logic [7:0] reload_val;
		logic set_reload;
		logic enable;
		logic disable_req;
		logic restore;
		logic [7:0] restore_ctr;
		logic restore_on;
	} irq_cmd_t;

	typedef struct packed {
		logic [7:0] ctr;
		logic on;
		logic pend;
		logic reload_req;
	} irq_state_t;

	typedef struct packed {
		logic [18:0] prg_addr;
		logic [17:0] chr_addr;
		logic prg_oe;
		logic chr_oe;
		logic rom_ce;
		logic ram_ce;
		logic ram_we;
		logic chr_ce;
		logic chr_we;
		logic ciram_a10;
		logic ciram_ce;
		logic map_cpu_oe;
		logic [7:0] map_cpu_dout;
	} map_out_t;

endpackage

`default_nettype wire

// ==== mmc3_scanline_irq.sv ====
`default_nettype none

module mmc3_scanline_irq import mmc3_pkg::*;
(
	input wire m2,
	input wire map_rst,
	input wire ppu_a12,
	input wire irq_cmd_t irq_cmd,
	input wire freeze,
	output irq_state_t irq_state,
	output logic irq
);

	logic [A12_QUIET_LEN-1:0] a12_hist; // previous a12 samples, newest in bit 0
	logic [7:0] ctr;
	logic on;
	logic pend;
	logic reload_req;
	logic a12_rise;
	logic fire;

	// a rise only counts after a full quiet window
	assign a12_rise = ppu_a12 && (a12_hist == '0) && !freeze;

	// this rise would bring the counter to zero
	assign fire = on && a12_rise &&
		((ctr == 8'd1 && !reload_req) || (reload_req && irq_cmd.reload_val == 8'd0));

	assign irq = pend || fire;

	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			a12_hist <= '0;
			ctr <= 8'd0;
			on <= 1'b0;
			pend <= 1'b0;
			reload_req <= 1'b0;
		end
		else
		begin
			if (!freeze)
				a12_hist <= {a12_hist[A12_QUIET_LEN-2:0], ppu_a12};

			if (a12_rise)
			begin
				if (reload_req || ctr == 8'd0)
					ctr <= irq_cmd.reload_val;
				else
					ctr <= ctr - 8'd1;
				reload_req <= 1'b0;
				if (fire)
					pend <= 1'b1;
			end

			// cpu commands land after the counter so a c001 write wins
			if (irq_cmd.set_reload)
				reload_req <= 1'b1;
			if (irq_cmd.enable)
				on <= 1'b1;
			if (irq_cmd.disable_req)
			begin
				on <= 1'b0;
				pend <= 1'b0; // acknowledge
			end

			// save-state restore
			if (irq_cmd.restore)
				ctr <= irq_cmd.restore_ctr;
			if (irq_cmd.restore_on)
			begin
				reload_req <= irq_cmd.restore_ctr[1] ^ irq_cmd.restore_ctr[0];
				pend <= irq_cmd.restore_ctr[3] ^ irq_cmd.restore_ctr[2];
				on <= irq_cmd.restore_ctr[4];
			end
		end
	end

	always_comb
	begin
		irq_state.ctr = ctr;
		irq_state.on = on;
		irq_state.pend = pend;
		irq_state.reload_req = reload_req;
	end

endmodule

`default_nettype wire

// ==== mmc3_regs.sv ====
`default_nettype none

module mmc3_regs import mmc3_pkg::*;
(
	input wire m2,
	input wire map_rst,
	input wire cfg_mir_v,
	input wire cpu_bus_t cpu,
	input wire irq_state_t irq_state,
	input wire ss_cyc,
	input wire ss_stb,
	input wire ss_we,
	input wire [7:0] ss_adr,
	input wire [7:0] ss_dat_w,
	output bank_cfg_t bank_cfg,
	output irq_cmd_t irq_cmd,
	output logic [7:0] ss_dat_r,
	output logic ss_ack
);

	typedef enum logic [1:0] {
		st_idle,
		st_wait,
		st_ack,
		st_hold
	} ss_state_e;

	logic [7:0] cpu_regs [8];  // 8000-e001 as written
	logic [7:0] bank_regs [8]; // targets of 8001
	reg_sel_e reg_sel;
	logic cpu_wr;
	logic ss_wr;
	ss_state_e ss_state;

	assign reg_sel = reg_sel_e'({cpu.addr[14], cpu.addr[13], cpu.addr[0]});
	assign cpu_wr = !cpu.ce_n && !cpu.rw && !ss_cyc; // frozen during save state
	assign ss_wr = (ss_state == st_wait) && ss_cyc && ss_stb && ss_we;
	assign ss_ack = (ss_state == st_ack);

	// ****************************************
	// wishbone save-state handshake

	always_ff @(posedge m2)
	begin
		if (map_rst)
			ss_state <= st_idle;
		else
		begin
			case (ss_state)
				st_idle: if (ss_cyc && ss_stb)
					ss_state <= st_wait;
				st_wait: ss_state <= (ss_cyc && ss_stb) ? st_ack : st_idle;
				st_ack: ss_state <= (ss_cyc && ss_stb) ? st_hold : st_idle;
				default: if (!ss_cyc || !ss_stb)
					ss_state <= st_idle; // wait for the master to drop stb
			endcase
		end
	end

	// ****************************************
	// register file

	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			for (int i = 0; i < 8; i++)
				cpu_regs[i] <= 8'h00;
			cpu_regs[mirror] <= {7'b0, cfg_mir_v}; // board strap
			bank_regs[0] <= 8'd0;
			bank_regs[1] <= 8'd2;
			bank_regs[2] <= 8'd4;
			bank_regs[3] <= 8'd5;
			bank_regs[4] <= 8'd6;
			bank_regs[5] <= 8'd7;
			bank_regs[6] <= 8'd0;
			bank_regs[7] <= 8'd1;
		end
		else
		begin
			if (cpu_wr)
			begin
				cpu_regs[reg_sel] <= cpu.dat;
				if (reg_sel == bank_data)
					bank_regs[cpu_regs[bank_select][2:0]] <= cpu.dat;
			end
			if (ss_wr && ss_adr[7:3] == 5'd0)
				cpu_regs[ss_adr[2:0]] <= ss_dat_w;
			if (ss_wr && ss_adr[7:3] == 5'd1)
				bank_regs[ss_adr[2:0]] <= ss_dat_w;
		end
	end

	// ****************************************
	// outputs to the bank map and the counter

	always_comb
	begin
		for (int i = 0; i < 6; i++)
			bank_cfg.chr_bank[i] = bank_regs[i];
		bank_cfg.prg_bank[0] = bank_regs[6][5:0];
		bank_cfg.prg_bank[1] = bank_regs[7][5:0];
		bank_cfg.swap_control = cpu_regs[bank_select][6];
		bank_cfg.chr_invert = cpu_regs[bank_select][7];
		bank_cfg.mirror_mode = cpu_regs[mirror][0];
		bank_cfg.ram_on = cpu_regs[ram_cfg][7]; // bit 6 write protect is stored only
	end

	always_comb
	begin
		irq_cmd.reload_val = cpu_regs[irq_latch];
		irq_cmd.set_reload = cpu_wr && (reg_sel == irq_reload);
		irq_cmd.enable = cpu_wr && (reg_sel == irq_enable);
		irq_cmd.disable_req = cpu_wr && (reg_sel == irq_disable);
		irq_cmd.restore = ss_wr && (ss_adr == SS_IRQ_CTR_ADR);
		irq_cmd.restore_ctr = ss_dat_w;
		irq_cmd.restore_on = ss_wr && (ss_adr == SS_IRQ_FLAGS_ADR);
	end

	// save-state readback, valid while ss_ack is high
	always_comb
	begin
		if (ss_adr[7:3] == 5'd0)
			ss_dat_r = cpu_regs[ss_adr[2:0]];
		else if (ss_adr[7:3] == 5'd1)
			ss_dat_r = bank_regs[ss_adr[2:0]];
		else if (ss_adr == SS_IRQ_CTR_ADR)
			ss_dat_r = irq_state.ctr;
		else if (ss_adr == SS_IRQ_FLAGS_ADR)
			ss_dat_r = {3'b000, irq_state.on, irq_state.pend, 1'b0, irq_state.reload_req, 1'b0};
		else if (ss_adr == SS_MAP_IDX_ADR)
			ss_dat_r = MAP_IDX;
		else
			ss_dat_r = 8'hff;
	end

endmodule

`default_nettype wire

// ==== mmc3_bank_map.sv ====
`default_nettype none

module mmc3_bank_map import mmc3_pkg::*;
(
	input wire cpu_bus_t cpu,
	input wire ppu_bus_t ppu,
	input wire bank_cfg_t bank_cfg,
	output map_out_t map_out
);

	logic [5:0] prg_page;
	logic [7:0] chr_page;
	logic ram_area;

	assign ram_area = cpu.ce_n && (cpu.addr[14:13] == 2'b11); // 6000-7fff

	// ****************************************
	// prg, 8k windows

	always_comb
	begin
		case (cpu.addr[14:13])
			2'd0: prg_page = bank_cfg.swap_control ? PRG_FIXED_SECOND : bank_cfg.prg_bank[0];
			2'd1: prg_page = bank_cfg.prg_bank[1];
			2'd2: prg_page = bank_cfg.swap_control ? bank_cfg.prg_bank[0] : PRG_FIXED_SECOND;
			default: prg_page = PRG_FIXED_LAST;
		endcase
		if (cpu.ce_n)
			prg_page = 6'd0; // below 8000
	end

	// ****************************************
	// chr, 1k pages

	always_comb
	begin
		if (ppu.addr[12:11] == {bank_cfg.chr_invert, 1'b0})
			chr_page = {bank_cfg.chr_bank[0][7:1], ppu.addr[10]}; // 2k bank, low bit ignored
		else if (ppu.addr[12:11] == {bank_cfg.chr_invert, 1'b1})
			chr_page = {bank_cfg.chr_bank[1][7:1], ppu.addr[10]};
		else
		begin
			case (ppu.addr[11:10])
				2'd0: chr_page = bank_cfg.chr_bank[2];
				2'd1: chr_page = bank_cfg.chr_bank[3];
				2'd2: chr_page = bank_cfg.chr_bank[4];
				default: chr_page = bank_cfg.chr_bank[5];
			endcase
		end
	end

	// ****************************************
	// cartridge edge

	always_comb
	begin
		map_out.prg_addr = {prg_page, cpu.addr[12:0]};
		map_out.chr_addr = {chr_page, ppu.addr[9:0]};
		map_out.prg_oe = cpu.rw;
		map_out.chr_oe = !ppu.oe_n;
		map_out.rom_ce = !cpu.ce_n;
		map_out.ram_ce = ram_area;
		map_out.ram_we = ram_area && !cpu.rw;
		map_out.chr_ce = !ppu.addr[13];
		map_out.chr_we = !ppu.we_n;
		map_out.ciram_a10 = bank_cfg.mirror_mode ? ppu.addr[11] : ppu.addr[10];
		map_out.ciram_ce = !ppu.addr[13];
		map_out.map_cpu_oe = ram_area && !bank_cfg.ram_on && cpu.rw; // open bus
		map_out.map_cpu_dout = 8'hff;
	end

endmodule

`default_nettype wire

// ==== mmc3_mapper.sv ====
`default_nettype none

module mmc3_mapper import mmc3_pkg::*;
(
	input wire m2,
	input wire map_rst,
	input wire cfg_mir_v,
	input wire cpu_bus_t cpu,
	input wire ppu_bus_t ppu,
	input wire ss_cyc,
	input wire ss_stb,
	input wire ss_we,
	input wire [7:0] ss_adr,
	input wire [7:0] ss_dat_w,
	output map_out_t map_out,
	output logic irq,
	output logic [7:0] ss_dat_r,
	output logic ss_ack
);

	bank_cfg_t bank_cfg;
	irq_cmd_t irq_cmd;
	irq_state_t irq_state;

	mmc3_regs u_regs (
		.m2        (m2),
		.map_rst   (map_rst),
		.cfg_mir_v (cfg_mir_v),
		.cpu       (cpu),
		.irq_state (irq_state),
		.ss_cyc    (ss_cyc),
		.ss_stb    (ss_stb),
		.ss_we     (ss_we),
		.ss_adr    (ss_adr),
		.ss_dat_w  (ss_dat_w),
		.bank_cfg  (bank_cfg),
		.irq_cmd   (irq_cmd),
		.ss_dat_r  (ss_dat_r),
		.ss_ack    (ss_ack)
	);

	mmc3_scanline_irq u_irq (
		.m2        (m2),
		.map_rst   (map_rst),
		.ppu_a12   (ppu.addr[12]),
		.irq_cmd   (irq_cmd),
		.freeze    (ss_cyc), // counting stops during save state
		.irq_state (irq_state),
		.irq       (irq)
	);

	mmc3_bank_map u_bank_map (
		.cpu      (cpu),
		.ppu      (ppu),
		.bank_cfg (bank_cfg),
		.map_out  (map_out)
	);

endmodule

`default_nettype wire

// ==== tb_mmc3.sv ====
`default_nettype none

module tb_mmc3 import mmc3_pkg::*;
();

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [7:0] adr;
		logic [7:0] dat;
	} ss_drive_t;

	localparam int N_DEFAULT = 100;
	localparam int N_BANK = 200;   // three cycles each
	localparam int N_MIRROR = 100; // three cycles each
	localparam int N_IRQ = 800;
	localparam int N_SS = 40;      // a write and a read of five cycles each
	localparam int N_CYCLES = 4 + N_DEFAULT + 3 * N_BANK + 3 * N_MIRROR + N_IRQ
		+ 10 * N_SS + 30;
	localparam int TIMEOUT = N_CYCLES * 4 + 400;

	logic m2 = 1'b0;
	logic map_rst;
	logic cfg_mir_v;
	cpu_bus_t cpu;
	ppu_bus_t ppu;
	ss_drive_t ss_m;
	map_out_t map_out;
	logic irq;
	logic [7:0] ss_dat_r;
	logic ss_ack;
	logic [31:0] lfsr;
	logic [7:0] last_read;

	// ****************************************
	// reference model state

	logic [7:0] m_cpu [8];
	logic [7:0] m_bank [8];
	logic [7:0] m_ctr;
	logic m_on;
	logic m_pend;
	logic m_reload;
	int m_low_run;  // saturating count of a12 low samples in a row
	int m_ss_cnt;   // saturating count of edges with cyc and stb high

	mmc3_mapper uut (
		.m2        (m2),
		.map_rst   (map_rst),
		.cfg_mir_v (cfg_mir_v),
		.cpu       (cpu),
		.ppu       (ppu),
		.ss_cyc    (ss_m.cyc),
		.ss_stb    (ss_m.stb),
		.ss_we     (ss_m.we),
		.ss_adr    (ss_m.adr),
		.ss_dat_w  (ss_m.dat),
		.map_out   (map_out),
		.irq       (irq),
		.ss_dat_r  (ss_dat_r),
		.ss_ack    (ss_ack)
	);

	always #2 m2 = !m2;

	initial
	begin
		#(TIMEOUT);
		$display("timeout: the run did not finish within %0d time units", TIMEOUT);
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

	// fibonacci lfsr with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic compare(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("error at time %0t: %s is %h, expected %h", $time, what, got, expected);
			$display("ERRORS FOUND");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic ppu_bus_t rand_ppu();
		ppu_bus_t p;
		p.addr = 14'(rand_bits(14));
		p.oe_n = 1'(rand_bits(1));
		p.we_n = 1'(rand_bits(1));
		return p;
	endfunction

	function automatic cpu_bus_t rand_read();
		cpu_bus_t c;
		c.ce_n = 1'(rand_bits(1));
		c.rw = 1'b1;
		c.addr = 15'(rand_bits(15));
		c.dat = 8'(rand_bits(8));
		return c;
	endfunction

	function automatic cpu_bus_t cpu_write(input logic [14:0] adr, input logic [7:0] dat);
		return '{ce_n: 1'b0, rw: 1'b0, addr: adr, dat: dat};
	endfunction

	// ****************************************
	// expected values from the model

	function automatic logic model_rise();
		return ppu.addr[12] && m_low_run >= A12_QUIET_LEN && !ss_m.cyc;
	endfunction

	function automatic logic model_fire();
		return m_on && model_rise()
			&& (m_reload ? m_cpu[irq_latch] == 8'd0 : m_ctr == 8'd1);
	endfunction

	function automatic logic [18:0] exp_prg();
		logic [1:0] win;
		logic [5:0] page;
		win = cpu.addr[14:13];
		if (m_cpu[bank_select][6] && !win[0])
			win[1] = !win[1]; // swap mode trades the 8000 and c000 windows
		case (win)
			2'd0: page = m_bank[6][5:0];
			2'd1: page = m_bank[7][5:0];
			2'd2: page = PRG_FIXED_SECOND;
			default: page = PRG_FIXED_LAST;
		endcase
		if (cpu.ce_n)
			page = 6'd0;
		return {page, cpu.addr[12:0]};
	endfunction

	function automatic logic [17:0] exp_chr();
		logic [2:0] k;
		logic [7:0] page;
		k = ppu.addr[12:10] ^ {m_cpu[bank_select][7], 2'b00}; // 1k slot after inversion
		if (!k[2])
			page = {m_bank[{2'b00, k[1]}][7:1], k[0]};
		else
			page = m_bank[3'd2 + {1'b0, k[1:0]}];
		return {page, ppu.addr[9:0]};
	endfunction

	function automatic logic [7:0] exp_ss_read();
		if (ss_m.adr < 8'd8)
			return m_cpu[ss_m.adr[2:0]];
		if (ss_m.adr < 8'd16)
			return m_bank[ss_m.adr[2:0]];
		if (ss_m.adr == SS_IRQ_CTR_ADR)
			return m_ctr;
		if (ss_m.adr == SS_IRQ_FLAGS_ADR)
			return {3'b000, m_on, m_pend, 1'b0, m_reload, 1'b0};
		if (ss_m.adr == SS_MAP_IDX_ADR)
			return 8'd74;
		return 8'hff;
	endfunction

	task automatic check_outputs();
		logic ram_area;
		ram_area = cpu.ce_n && cpu.addr[14:13] == 2'b11;
		compare("prg_addr", 32'(map_out.prg_addr), 32'(exp_prg()));
		compare("chr_addr", 32'(map_out.chr_addr), 32'(exp_chr()));
		compare("prg_oe", 32'(map_out.prg_oe), 32'(cpu.rw));
		compare("chr_oe", 32'(map_out.chr_oe), 32'(!ppu.oe_n));
		compare("rom_ce", 32'(map_out.rom_ce), 32'(!cpu.ce_n));
		compare("ram_ce", 32'(map_out.ram_ce), 32'(ram_area));
		compare("chr_ce", 32'(map_out.chr_ce), 32'(!ppu.addr[13]));
		compare("chr_we", 32'(map_out.chr_we), 32'(!ppu.we_n));
		compare("ciram_a10", 32'(map_out.ciram_a10),
			32'(ppu.addr[10 + int'(m_cpu[mirror][0])]));
		compare("ciram_ce", 32'(map_out.ciram_ce), 32'(!ppu.addr[13]));
		compare("ram_we", 32'(map_out.ram_we), 32'(ram_area && !cpu.rw));
		compare("map_cpu_oe", 32'(map_out.map_cpu_oe),
			32'(ram_area && !m_cpu[ram_cfg][7] && cpu.rw));
		compare("map_cpu_dout", 32'(map_out.map_cpu_dout), 32'hff);
		compare("irq", 32'(irq), 32'(m_pend || model_fire()));
		compare("ss_ack", 32'(ss_ack), 32'(m_ss_cnt == 2));
		if (m_ss_cnt == 2)
			compare("ss_dat_r", 32'(ss_dat_r), 32'(exp_ss_read()));
	endtask

	// inputs change on the falling edge, outputs are checked 1 unit later
	task automatic bus_cycle(input cpu_bus_t c, input ppu_bus_t p, input ss_drive_t s);
		@(negedge m2);
		cpu = c;
		ppu = p;
		ss_m = s;
		#1;
		check_outputs();
	endtask

	task automatic ss_access(input logic we, input logic [7:0] adr, input logic [7:0] dat);
		ss_drive_t s;
		ppu_bus_t p;
		int edges;
		s = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		edges = 0;
		bus_cycle(cpu_write(15'(rand_bits(15)), 8'(rand_bits(8))), rand_ppu(), s);
		while (!ss_ack)
		begin
			if (edges > 8)
			begin
				$display("save-state access to address %0d was never acknowledged",
					adr);
				$display("ERRORS FOUND");
				$fatal(1, "missing ack");
			end
			bus_cycle(cpu_write(15'(rand_bits(15)), 8'(rand_bits(8))), rand_ppu(), s);
			edges++;
		end
		last_read = ss_dat_r;
		bus_cycle(cpu_write(15'(rand_bits(15)), 8'(rand_bits(8))), rand_ppu(), s);
		p = rand_ppu();
		p.addr[12] = 1'b0; // keep the counter still between accesses
		bus_cycle(rand_read(), p, '0);
	endtask

	// ****************************************
	// model update on the rising edge

	always @(posedge m2)
	begin : model_update
		logic rise;
		logic fire;
		logic cpu_wr;
		logic ss_wr;
		reg_sel_e sel;
		if (map_rst)
		begin
			for (int i = 0; i < 8; i++)
				m_cpu[i] = 8'h00;
			m_cpu[mirror] = {7'd0, cfg_mir_v};
			m_bank = '{8'd0, 8'd2, 8'd4, 8'd5, 8'd6, 8'd7, 8'd0, 8'd1};
			m_ctr = 8'd0;
			m_on = 1'b0;
			m_pend = 1'b0;
			m_reload = 1'b0;
			m_low_run = A12_QUIET_LEN;
			m_ss_cnt = 0;
		end
		else
		begin
			rise = model_rise();
			fire = model_fire();
			cpu_wr = !cpu.ce_n && !cpu.rw && !ss_m.cyc;
			ss_wr = ss_m.cyc && ss_m.stb && ss_m.we && m_ss_cnt == 1;
			sel = reg_sel_e'({cpu.addr[14], cpu.addr[13], cpu.addr[0]});
			if (rise)
			begin
				if (m_reload || m_ctr == 8'd0)
					m_ctr = m_cpu[irq_latch];
				else
					m_ctr = m_ctr - 8'd1;
				m_reload = 1'b0;
				m_pend = m_pend || fire;
			end
			if (!ss_m.cyc)
			begin
				if (ppu.addr[12])
					m_low_run = 0;
				else if (m_low_run < A12_QUIET_LEN)
					m_low_run++;
			end
			if (cpu_wr)
			begin
				case (sel)
					bank_data: m_bank[m_cpu[bank_select][2:0]] = cpu.dat;
					irq_reload: m_reload = 1'b1;
					irq_enable: m_on = 1'b1;
					irq_disable:
					begin
						m_on = 1'b0;
						m_pend = 1'b0;
					end
					default: ;
				endcase
				m_cpu[sel] = cpu.dat;
			end
			if (ss_wr)
			begin
				if (ss_m.adr < 8'd8)
					m_cpu[ss_m.adr[2:0]] = ss_m.dat;
				else if (ss_m.adr < 8'd16)
					m_bank[ss_m.adr[2:0]] = ss_m.dat;
				else if (ss_m.adr == SS_IRQ_CTR_ADR)
					m_ctr = ss_m.dat;
				else if (ss_m.adr == SS_IRQ_FLAGS_ADR)
				begin
					m_on = ss_m.dat[4];
					m_pend = ss_m.dat[3] ^ ss_m.dat[2];
					m_reload = ss_m.dat[1] ^ ss_m.dat[0];
				end
			end
			if (!(ss_m.cyc && ss_m.stb))
				m_ss_cnt = 0;
			else if (m_ss_cnt < 3)
				m_ss_cnt++;
		end
	end

	// ****************************************
	// stimulus

	initial
	begin
		cpu_bus_t c;
		ppu_bus_t p;
		logic [2:0] sel;
		logic [7:0] adr;
		logic [7:0] dat;
		logic a12;
		int a12_left;
		lfsr = 32'h5ebfc17f;
		map_rst = 1'b1;
		cfg_mir_v = 1'b1;
		cpu = rand_read();
		ppu = rand_ppu();
		ss_m = '0;
		repeat (2) @(posedge m2);
		@(negedge m2);
		map_rst = 1'b0;

		repeat (N_DEFAULT)
			bus_cycle(rand_read(), rand_ppu(), '0); // default banks

		for (int i = 0; i < N_BANK; i++)
		begin
			bus_cycle(cpu_write(15'h0000, 8'(rand_bits(8))), rand_ppu(), '0);
			bus_cycle(cpu_write(15'h0001, 8'(rand_bits(8))), rand_ppu(), '0);
			bus_cycle(rand_read(), rand_ppu(), '0);
		end

		for (int i = 0; i < N_MIRROR; i++)
		begin
			bus_cycle(cpu_write(15'h2000, 8'(rand_bits(8))), rand_ppu(), '0);
			bus_cycle(cpu_write(15'h2001, 8'(rand_bits(8))), rand_ppu(), '0);
			c = '{ce_n: 1'b1, rw: 1'(rand_bits(1)), addr: {2'b11, 13'(rand_bits(13))},
				dat: 8'(rand_bits(8))}; // work-ram window
			bus_cycle(c, rand_ppu(), '0);
		end

		// a12 pulse trains with irq register writes mixed in
		a12 = 1'b0;
		a12_left = 0;
		for (int i = 0; i < N_IRQ; i++)
		begin
			if (a12_left == 0)
			begin
				a12 = !a12;
				if (a12)
					a12_left = 1 + int'(rand_bits(1));
				else
					a12_left = 1 + int'(rand_bits(3)); // gaps of 1 to 8
			end
			a12_left--;
			p = rand_ppu();
			p.addr[12] = a12;
			sel = {1'b1, 2'(rand_bits(2))};
			if (rand_bits(2) == 32'd0)
				c = cpu_write({sel[2], sel[1], 12'd0, sel[0]}, 8'(rand_bits(3)));
			else
				c = rand_read();
			bus_cycle(c, p, '0);
		end

		// counter and flags left by the pulse trains
		ss_access(1'b0, SS_IRQ_CTR_ADR, 8'h00);
		ss_access(1'b0, SS_IRQ_FLAGS_ADR, 8'h00);

		for (int i = 0; i < N_SS; i++)
		begin
			adr = 8'(rand_bits(5) % 32'd18);
			dat = 8'(rand_bits(8));
			ss_access(1'b1, adr, dat);
			ss_access(1'b0, adr, 8'h00);
			if (adr < SS_IRQ_FLAGS_ADR)
				compare("save-state readback", 32'(last_read), 32'(dat));
		end
		ss_access(1'b0, 8'd127, 8'h00);
		compare("mapper number", 32'(last_read), 32'd74);
		ss_access(1'b0, 8'd100, 8'h00);
		compare("unmapped save-state read", 32'(last_read), 32'hff);

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
mmc3_pkg.sv
mmc3_scanline_irq.sv
mmc3_regs.sv
mmc3_bank_map.sv
mmc3_mapper.sv
tb_mmc3.sv

// ==== Makefile ====
VERILATOR = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS = --binary --timing
TOP = tb_mmc3
FILELIST = all.f
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "NO ERRORS" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
